/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = tb_uart_bridge
FILELIST  = sources.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(BUILD_DIR)

/* logic/bridge_pkg.sv */
package bridge_pkg;

  localparam int CSUM_W = 8;  // block read checksum, modulo 256

  // command groups keep the low nibble clear, memory commands use the full byte
  typedef enum logic [7:0] {
    OP_IDLE    = 8'h00,
    OP_LINE    = 8'h10,  // dut clock / reset lines
    OP_PIN_RD  = 8'h20,
    OP_PIN_WR  = 8'h30,
    OP_UREG_WR = 8'h40,
    OP_RREG_RD = 8'h50,
    OP_PIN_REL = 8'h60,
    OP_MEM_WR  = 8'hA0,
    OP_MEM_RD  = 8'hA1,
    OP_BLK_WR  = 8'hA2,
    OP_BLK_RD  = 8'hA3
  } cmd_op_t;

  typedef enum logic [2:0] {
    ST_WAIT_CMD,
    ST_DECODE,
    ST_WAIT_DATA,
    ST_WAIT_TX,
    ST_MEM_REQ,
    ST_BLK_STEP,
    ST_DONE
  } engine_state_t;

  typedef struct packed {
    logic [23:0] addr;
    logic [15:0] wdata;
    logic        rd_req;
    logic        wr_req;
    logic        stream_we;     // one word per cycle, no ack
    logic        stream_latch;  // load stream pointer from addr
  } mem_req_t;

  typedef struct packed {
    logic [15:0] rdata;
    logic        rd_ack;
    logic        wr_ack;
  } mem_rsp_t;

  typedef logic [7:0][7:0] pin_bank_t;  // eight byte-wide banks

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_byte_t;

endpackage

/* logic/uart_bridge_top.sv */
`timescale 1ns/1ns

module uart_bridge_top #(
  parameter int CLKS_PER_BIT   = 434,  // 50 MHz at 115200 baud
  parameter int BLOCK_WORDS    = 256,
  parameter int MEM_DEPTH_LOG2 = 16
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  uart_rxd,
  output logic                  uart_txd,
  input  bridge_pkg::pin_bank_t in_pins,
  output bridge_pkg::pin_bank_t out_pins,
  output logic [7:0]            out_oe,
  output logic                  out_clk,
  output logic                  out_rst,
  output logic                  busy
);

  import bridge_pkg::*;

  uart_byte_t rx_byte;
  uart_byte_t tx_byte;
  logic       tx_ready;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_rx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .rxd       (uart_rxd),
    .rx_byte   (rx_byte)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_tx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .tx_byte   (tx_byte),
    .tx_ready  (tx_ready),
    .txd       (uart_txd)
  );

  uart_cmd_engine #(
    .BLOCK_WORDS (BLOCK_WORDS)
  ) i_engine (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .rx_byte   (rx_byte),
    .tx_byte   (tx_byte),
    .tx_ready  (tx_ready),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .in_pins   (in_pins),
    .out_pins  (out_pins),
    .out_oe    (out_oe),
    .out_clk   (out_clk),
    .out_rst   (out_rst),
    .busy      (busy)
  );

  // stands in for the sdram controller port
  word_mem #(
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
  ) i_word_mem (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

endmodule

/* logic/uart_cmd_engine.sv */
`timescale 1ns/1ns

module uart_cmd_engine #(
  parameter int BLOCK_WORDS = 8
) (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  bridge_pkg::uart_byte_t rx_byte,
  output bridge_pkg::uart_byte_t tx_byte,
  input  logic                   tx_ready,
  output bridge_pkg::mem_req_t   mem_req,
  input  bridge_pkg::mem_rsp_t   mem_rsp,
  input  bridge_pkg::pin_bank_t  in_pins,
  output bridge_pkg::pin_bank_t  out_pins,
  output logic [7:0]             out_oe,
  output logic                   out_clk,
  output logic                   out_rst,
  output logic                   busy
);

  import bridge_pkg::*;

  localparam int CNT_W = $clog2(2 * BLOCK_WORDS + 1);
  localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(2 * BLOCK_WORDS - 1);
  localparam logic [CNT_W-1:0] WORDS_END = CNT_W'(BLOCK_WORDS);

  engine_state_t     state;
  logic [7:0]        cmd_q;
  cmd_op_t           op;
  logic [2:0]        sel;      // bank or register index
  logic              sel_ok;
  pin_bank_t         user_regs;
  pin_bank_t         res_regs;
  logic [7:0]        lo_q;     // low byte of block write word
  logic [7:0]        hi_q;     // high byte still to send
  logic              hi_next;
  logic              last_tx;  // checksum queued
  logic [CNT_W-1:0]  xfer_cnt; // bytes for A2, words for A3
  logic [7:0]        cyc_cnt;
  logic [CSUM_W-1:0] sum;
  logic              tx_fire;

  assign op      = cmd_op_t'((cmd_q[7:4] == 4'hA) ? cmd_q : {cmd_q[7:4], 4'h0});
  assign sel     = cmd_q[2:0];
  assign sel_ok  = !cmd_q[3];
  assign tx_fire = tx_byte.valid && tx_ready;
  assign busy    = (state != ST_WAIT_CMD);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= ST_WAIT_CMD;
      cmd_q     <= '0;
      user_regs <= '0;
      res_regs  <= '0;
      out_pins  <= '0;
      out_oe    <= '0;
      out_clk   <= 1'b0;
      out_rst   <= 1'b0;
      tx_byte   <= '0;
      mem_req   <= '0;
      lo_q      <= '0;
      hi_q      <= '0;
      hi_next   <= 1'b0;
      last_tx   <= 1'b0;
      xfer_cnt  <= '0;
      cyc_cnt   <= '0;
      sum       <= '0;
    end else begin
      mem_req.stream_we    <= 1'b0;  // stream strobes are one cycle
      mem_req.stream_latch <= 1'b0;
      case (state)
        ST_WAIT_CMD: begin
          if (rx_byte.valid) begin
            cmd_q <= rx_byte.data;
            state <= ST_DECODE;
          end
        end
        ST_DECODE: begin
          state <= ST_DONE;  // most commands finish here
          case (op)
            OP_LINE: begin
              if (cmd_q[3:2] == 2'b00) begin
                // odd code clears, even code sets
                if (cmd_q[1]) begin
                  out_rst <= !cmd_q[0];
                end else begin
                  out_clk <= !cmd_q[0];
                end
              end
            end
            OP_PIN_RD: begin
              if (sel_ok) begin
                tx_byte <= '{valid: 1'b1, data: in_pins[sel]};
                state   <= ST_WAIT_TX;
              end
            end
            OP_RREG_RD: begin
              if (sel_ok) begin
                tx_byte <= '{valid: 1'b1, data: res_regs[sel]};
                state   <= ST_WAIT_TX;
              end
            end
            OP_PIN_WR, OP_UREG_WR: begin
              if (sel_ok) begin
                state <= ST_WAIT_DATA;
              end
            end
            OP_PIN_REL: begin
              if (sel_ok) begin
                out_oe[sel] <= 1'b0;
              end
            end
            OP_MEM_WR: begin
              mem_req.addr   <= {user_regs[4], user_regs[3], user_regs[2]};
              mem_req.wdata  <= {user_regs[1], user_regs[0]};
              mem_req.wr_req <= 1'b1;
              cyc_cnt        <= 8'd1;
              state          <= ST_MEM_REQ;
            end
            OP_MEM_RD: begin
              mem_req.addr   <= {user_regs[4], user_regs[3], user_regs[2]};
              mem_req.rd_req <= 1'b1;
              cyc_cnt        <= 8'd1;
              state          <= ST_MEM_REQ;
            end
            OP_BLK_WR: begin
              mem_req.addr <= {user_regs[4], user_regs[3], user_regs[2]};
              xfer_cnt     <= '0;
              state        <= ST_BLK_STEP;
            end
            OP_BLK_RD: begin
              mem_req.addr   <= {user_regs[4], user_regs[3], user_regs[2]};
              mem_req.rd_req <= 1'b1;
              xfer_cnt       <= '0;
              sum            <= '0;
              last_tx        <= 1'b0;
              state          <= ST_MEM_REQ;
            end
            default: ;  // unknown codes are dropped
          endcase
        end
        ST_WAIT_DATA: begin
          if (rx_byte.valid) begin
            if (op == OP_PIN_WR) begin
              out_pins[sel] <= rx_byte.data;
              out_oe[sel]   <= 1'b1;
            end else begin
              user_regs[sel] <= rx_byte.data;
            end
            state <= ST_DONE;
          end
        end
        ST_WAIT_TX: begin
          if (tx_fire) begin
            tx_byte.valid <= 1'b0;
            state         <= (op == OP_BLK_RD && !last_tx) ? ST_BLK_STEP : ST_DONE;
          end
        end
        ST_MEM_REQ: begin
          cyc_cnt <= cyc_cnt + 8'd1;
          if (mem_req.wr_req && mem_rsp.wr_ack) begin
            mem_req.wr_req <= 1'b0;
            res_regs[7]    <= cyc_cnt;
            state          <= ST_DONE;
          end
          if (mem_req.rd_req && mem_rsp.rd_ack) begin
            mem_req.rd_req <= 1'b0;
            if (op == OP_BLK_RD) begin
              hi_q    <= mem_rsp.rdata[15:8];
              hi_next <= 1'b1;
              sum     <= sum + mem_rsp.rdata[7:0];
              tx_byte <= '{valid: 1'b1, data: mem_rsp.rdata[7:0]};  // low byte first
              state   <= ST_WAIT_TX;
            end else begin
              res_regs[0] <= mem_rsp.rdata[7:0];
              res_regs[1] <= mem_rsp.rdata[15:8];
              res_regs[7] <= cyc_cnt;
              state       <= ST_DONE;
            end
          end
        end
        ST_BLK_STEP: begin
          if (op == OP_BLK_WR) begin
            if (rx_byte.valid) begin
              xfer_cnt <= xfer_cnt + CNT_W'(1);
              if (!xfer_cnt[0]) begin
                lo_q <= rx_byte.data;
              end else begin
                mem_req.wdata        <= {rx_byte.data, lo_q};
                mem_req.stream_we    <= 1'b1;
                mem_req.stream_latch <= (xfer_cnt == CNT_W'(1));  // first word sets pointer
                if (xfer_cnt == LAST_BYTE) begin
                  tx_byte <= '{valid: 1'b1, data: 8'h41};
                  state   <= ST_WAIT_TX;
                end
              end
            end
          end else if (hi_next) begin
            hi_next  <= 1'b0;
            sum      <= sum + hi_q;
            tx_byte  <= '{valid: 1'b1, data: hi_q};
            xfer_cnt <= xfer_cnt + CNT_W'(1);
            state    <= ST_WAIT_TX;
          end else if (xfer_cnt == WORDS_END) begin
            tx_byte <= '{valid: 1'b1, data: sum};
            last_tx <= 1'b1;
            state   <= ST_WAIT_TX;
          end else begin
            // next word of the block
            mem_req.addr   <= mem_req.addr + 24'd1;
            mem_req.rd_req <= 1'b1;
            state          <= ST_MEM_REQ;
          end
        end
        default: begin
          state <= ST_WAIT_CMD;  // ST_DONE, busy drops next cycle
        end
      endcase
    end
  end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  logic                   rxd,
  output bridge_pkg::uart_byte_t rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rxd_meta;
  logic             rxd_sync;
  logic             rxd_prev;  // for start edge
  logic [CNT_W-1:0] cyc_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift;
  logic             valid_q;

  // line idles high
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state   <= RX_IDLE;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          cyc_cnt <= '0;
          if (rxd_prev && !rxd_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (cyc_cnt == HALF) begin
            cyc_cnt <= '0;
            bit_cnt <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;  // glitch, not a start bit
          end else begin
            cyc_cnt <= cyc_cnt + CNT_W'(1);
          end
        end
        RX_DATA: begin
          if (cyc_cnt == FULL) begin
            cyc_cnt <= '0;
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cyc_cnt <= cyc_cnt + CNT_W'(1);
          end
        end
        default: begin
          if (cyc_cnt == FULL) begin
            valid_q <= rxd_sync;  // low stop bit drops the frame
            state   <= RX_IDLE;
          end else begin
            cyc_cnt <= cyc_cnt + CNT_W'(1);
          end
        end
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge sys_clk) begin
    if (state == RX_DATA && cyc_cnt == FULL) begin
      shift <= {rxd_sync, shift[7:1]};
    end
  end

  assign rx_byte = '{valid: valid_q, data: shift};

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  bridge_pkg::uart_byte_t tx_byte,
  output logic                   tx_ready,
  output logic                   txd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);

  logic             busy_q;
  logic [CNT_W-1:0] cyc_cnt;
  logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic [8:0]       shift;    // data plus stop bit
  logic             txd_q;

  assign tx_ready = !busy_q;
  assign txd      = txd_q;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      busy_q  <= 1'b0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      shift   <= '1;
      txd_q   <= 1'b1;
    end else if (!busy_q) begin
      if (tx_byte.valid) begin
        busy_q  <= 1'b1;
        shift   <= {1'b1, tx_byte.data};
        txd_q   <= 1'b0;  // start bit
        cyc_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (cyc_cnt != FULL) begin
      cyc_cnt <= cyc_cnt + CNT_W'(1);
    end else begin
      cyc_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // stop bit finished
        busy_q <= 1'b0;
        txd_q  <= 1'b1;
      end else begin
        txd_q   <= shift[0];
        shift   <= {1'b1, shift[8:1]};
        bit_cnt <= bit_cnt + 4'd1;
      end
    end
  end

endmodule

/* logic/word_mem.sv */
`timescale 1ns/1ns

module word_mem #(
  parameter int MEM_DEPTH_LOG2 = 10
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  bridge_pkg::mem_req_t mem_req,
  output bridge_pkg::mem_rsp_t mem_rsp
);

  localparam int DEPTH = 2 ** MEM_DEPTH_LOG2;

  logic [15:0]               mem [DEPTH];
  logic [MEM_DEPTH_LOG2-1:0] addr;
  logic [MEM_DEPTH_LOG2-1:0] ptr;       // stream write pointer
  logic                      start;
  logic                      pending;   // request seen, ack not yet given
  logic                      stage1;
  logic                      stage_wr;
  logic                      rd_ack_q;
  logic                      wr_ack_q;
  logic [15:0]               rdata_q;

  assign addr  = mem_req.addr[MEM_DEPTH_LOG2-1:0];
  assign start = (mem_req.rd_req || mem_req.wr_req) && !pending;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      pending  <= 1'b0;
      stage1   <= 1'b0;
      stage_wr <= 1'b0;
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      ptr      <= '0;
    end else begin
      if (start) begin
        pending  <= 1'b1;
        stage_wr <= mem_req.wr_req;  // write wins if both are raised
      end else if (rd_ack_q || wr_ack_q) begin
        pending <= 1'b0;
      end
      stage1   <= start;
      rd_ack_q <= stage1 && !stage_wr;
      wr_ack_q <= stage1 && stage_wr;
      // next stream word lands after the one just written
      if (mem_req.stream_we) begin
        ptr <= (mem_req.stream_latch ? addr : ptr) + MEM_DEPTH_LOG2'(1);
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mem_req.stream_we) begin
      mem[mem_req.stream_latch ? addr : ptr] <= mem_req.wdata;
    end else if (stage1 && stage_wr) begin
      mem[addr] <= mem_req.wdata;
    end
    if (stage1 && !stage_wr) begin
      rdata_q <= mem[addr];
    end
  end

  assign mem_rsp = '{rdata: rdata_q, rd_ack: rd_ack_q, wr_ack: wr_ack_q};

endmodule

/* sources.f */
logic/bridge_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_cmd_engine.sv
logic/word_mem.sv
logic/uart_bridge_top.sv
verif/tb_uart_bridge.sv

/* verif/tb_uart_bridge.sv */
`timescale 1ns/1ns

module tb_uart_bridge;

  import bridge_pkg::*;

  localparam int CLKS_PER_BIT   = 8;
  localparam int BLOCK_WORDS    = 8;
  localparam int MEM_DEPTH_LOG2 = 10;
  localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
  // longest command is a block read, 2 * BLOCK_WORDS + 2 frames
  localparam int WAIT_CYCLES    = 2 * (2 * BLOCK_WORDS + 2) * FRAME_CYCLES;
  localparam int QUIET_CYCLES   = 12 * CLKS_PER_BIT;  // longer than one frame
  // about 110 frames plus a quiet gap per command, roughly 3x margin
  localparam int MAX_CYCLES     = 40000;

  typedef logic [7:0] byte_q_t[$];

  logic       sys_clk;
  logic       sys_rst_n;
  logic       uart_rxd;
  logic       uart_txd;
  pin_bank_t  in_pins;
  pin_bank_t  out_pins;
  logic [7:0] out_oe;
  logic       out_clk;
  logic       out_rst;
  logic       busy;

  // reference model state
  pin_bank_t   ref_out;
  logic [7:0]  ref_oe;
  logic        ref_clk;
  logic        ref_rst;
  pin_bank_t   ref_user;
  pin_bank_t   ref_res;
  logic [15:0] ref_mem [2**MEM_DEPTH_LOG2];

  byte_q_t exp_q;  // reply bytes the DUT still owes
  integer  seed;
  int      cycles      = 0;
  int      checks      = 0;
  int      errors      = 0;
  int      tests       = 0;
  int      errs_before = 0;

  uart_bridge_top #(
    .CLKS_PER_BIT   (CLKS_PER_BIT),
    .BLOCK_WORDS    (BLOCK_WORDS),
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
  ) i_dut (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .uart_txd  (uart_txd),
    .in_pins   (in_pins),
    .out_pins  (out_pins),
    .out_oe    (out_oe),
    .out_clk   (out_clk),
    .out_rst   (out_rst),
    .busy      (busy)
  );

  initial sys_clk = 1'b0;
  always #20 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  // updates the model and queues the bytes the command should return
  function automatic void ref_model(input logic [7:0] cmd, input byte_q_t data);
    logic [23:0]               addr;
    logic [MEM_DEPTH_LOG2-1:0] idx;
    logic [2:0]                sel;
    logic [15:0]               word;
    logic [7:0]                sum;
    addr = {ref_user[4], ref_user[3], ref_user[2]};
    idx  = addr[MEM_DEPTH_LOG2-1:0];  // memory decodes low bits only
    sel  = cmd[2:0];
    sum  = 8'h00;
    if (cmd[7:4] == 4'hA) begin
      case (cmd[3:0])
        4'h0: ref_mem[idx] = {ref_user[1], ref_user[0]};
        4'h1: begin
          ref_res[0] = ref_mem[idx][7:0];
          ref_res[1] = ref_mem[idx][15:8];
        end
        4'h2: begin
          for (int i = 0; i < BLOCK_WORDS; i++) begin
            ref_mem[idx + MEM_DEPTH_LOG2'(i)] = {data[2*i+1], data[2*i]};  // low byte first
          end
          exp_q.push_back(8'h41);
        end
        4'h3: begin
          for (int i = 0; i < BLOCK_WORDS; i++) begin
            word = ref_mem[idx + MEM_DEPTH_LOG2'(i)];
            exp_q.push_back(word[7:0]);
            exp_q.push_back(word[15:8]);
            sum = sum + word[7:0] + word[15:8];
          end
          exp_q.push_back(sum);
        end
        default: ;
      endcase
    end else if (!cmd[3]) begin
      case (cmd[7:4])
        4'h1: begin
          if (!cmd[2]) begin
            if (cmd[1]) begin
              ref_rst = !cmd[0];
            end else begin
              ref_clk = !cmd[0];
            end
          end
        end
        4'h2: exp_q.push_back(in_pins[sel]);
        4'h3: begin
          ref_out[sel] = data[0];
          ref_oe[sel]  = 1'b1;
        end
        4'h4: ref_user[sel] = data[0];
        4'h5: exp_q.push_back(ref_res[sel]);
        4'h6: ref_oe[sel] = 1'b0;
        default: ;
      endcase
    end
  endfunction

  // host side, start bit, 8 data bits lsb first, stop bit
  task automatic drive_serial(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rxd = frame[i];
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
    end
  endtask

  task automatic sample_serial(output logic [7:0] b, output logic framed);
    @(negedge uart_txd);
    repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);  // mid start bit
    framed = (uart_txd == 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      b[i] = uart_txd;
    end
    repeat (CLKS_PER_BIT) @(negedge sys_clk);
    framed = framed && uart_txd;
  endtask

  task automatic await_not_busy(input logic [7:0] cmd);
    int n;
    n = 0;
    check("busy", 64'(1), 64'(busy));  // last byte was taken one cycle ago
    while (busy !== 1'b0 && n < WAIT_CYCLES) begin
      @(negedge sys_clk);
      n++;
    end
    if (busy !== 1'b0) begin
      errors++;
      $display("timeout: busy stayed high after command %02h", cmd);
    end
  endtask

  task automatic drain_replies(input logic [7:0] cmd);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_CYCLES) begin
      @(negedge sys_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: %0d reply bytes never arrived after command %02h",
               exp_q.size(), cmd);
      exp_q = {};
    end
    repeat (QUIET_CYCLES) @(negedge sys_clk);  // room for a stray extra byte
  endtask

  task automatic compare_outputs();
    check("out_pins", 64'(ref_out), 64'(out_pins));
    check("out_oe", 64'(ref_oe), 64'(out_oe));
    check("out_clk", 64'(ref_clk), 64'(out_clk));
    check("out_rst", 64'(ref_rst), 64'(out_rst));
    check("busy", 64'(0), 64'(busy));
  endtask

  task automatic transact(input logic [7:0] cmd, input byte_q_t data);
    ref_model(cmd, data);
    drive_serial(cmd);
    foreach (data[i]) begin
      drive_serial(data[i]);  // back to back, no gap
    end
    await_not_busy(cmd);
    drain_replies(cmd);
    compare_outputs();
  endtask

  task automatic plain_command(input logic [7:0] cmd);
    byte_q_t none;
    transact(cmd, none);
  endtask

  task automatic write_command(input logic [7:0] cmd, input logic [7:0] b);
    byte_q_t one;
    one.push_back(b);
    transact(cmd, one);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    errs_before = errors;
    tests++;
  endtask

  // every byte from the DUT is matched against the model queue
  initial begin : compare_replies
    logic [7:0] got;
    logic       framed;
    wait (sys_rst_n === 1'b1);
    forever begin
      sample_serial(got, framed);
      if (!framed) begin
        errors++;
        $display("framing error: bad start or stop bit on uart_txd at %0t ns", $time);
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected byte %02h from the DUT at %0t ns", got, $time);
      end else begin
        check("uart_txd byte", 64'(exp_q.pop_front()), 64'(got));
      end
    end
  end

  initial begin : stimulus
    byte_q_t blk;
    seed      = 32'h647;
    sys_rst_n = 1'b0;
    uart_rxd  = 1'b1;
    in_pins   = '0;
    ref_out   = '0;
    ref_oe    = '0;
    ref_clk   = 1'b0;
    ref_rst   = 1'b0;
    ref_user  = '0;
    ref_res   = '0;
    repeat (16) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    @(negedge sys_clk);

    check("uart_txd", 64'(1), 64'(uart_txd));  // idle line after reset
    compare_outputs();
    for (int n = 0; n < 8; n++) begin
      write_command(8'h30 + 8'(n), 8'($random(seed)));
    end
    plain_command(8'h61);
    plain_command(8'h64);
    plain_command(8'h66);
    report_test(1, "pin write and release");

    in_pins = {$random(seed), $random(seed)};
    for (int n = 0; n < 8; n++) begin
      plain_command(8'h20 + 8'(n));
    end
    report_test(2, "pin read");

    plain_command(8'h10);
    plain_command(8'h12);
    plain_command(8'h7F);
    plain_command(8'h11);
    plain_command(8'h13);
    plain_command(8'hF5);
    report_test(3, "line control and unknown opcodes");

    write_command(8'h44, 8'($random(seed)));
    write_command(8'h43, 8'($random(seed)));
    write_command(8'h42, 8'($random(seed)));
    write_command(8'h41, 8'($random(seed)));
    write_command(8'h40, 8'($random(seed)));
    plain_command(8'hA0);
    write_command(8'h40, 8'($random(seed)));  // must not leak into the read back
    write_command(8'h41, 8'($random(seed)));
    plain_command(8'hA1);
    plain_command(8'h50);
    plain_command(8'h51);
    report_test(4, "single memory transfer");

    write_command(8'h42, 8'($random(seed)));
    write_command(8'h43, 8'($random(seed)));
    for (int i = 0; i < 2 * BLOCK_WORDS; i++) begin
      blk.push_back(8'($random(seed)));
    end
    transact(8'hA2, blk);
    plain_command(8'hA3);
    report_test(5, "block write then block read");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
